//--- passive_snoop_responder.f
hdl/snoop_pkg.sv
hdl/snoop_filter.sv
hdl/reply_delay_timer.sv
hdl/channel_hold.sv
hdl/reply_fsm.sv
hdl/passive_snoop_responder.sv
bench/snoop_sva.sv
bench/snoop_checker.sv
bench/tb_passive_snoop_responder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_passive_snoop_responder \
    -f passive_snoop_responder.f \
    -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -q "Verification failed" "$LOG" || ! grep -q "Verification passed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0

//--- bench/tb_passive_snoop_responder.sv
`timescale 1ns/1ps

module tb_passive_snoop_responder;

    localparam int N_ENTRIES     = 11;
    localparam int CLK_HALF      = 20;
    localparam int MARGIN_CYCLES = 200;

    // Outcome classes
    localparam logic [1:0] CLS_DUMMY = 2'd0;
    localparam logic [1:0] CLS_DELAY = 2'd1;
    localparam logic [1:0] CLS_DATA  = 2'd2;

    typedef struct packed {
        snoop_pkg::ctrl_t                   ctrl;
        snoop_pkg::snoop_req_t              snoop;
        logic [snoop_pkg::CACHE_LINE_W-1:0] line;
        logic [1:0]                         cls;
        logic                               retrig;
        logic                               oneshot;
    } entry_t;

    logic                               ace_aclk = 1'b0;
    logic                               ace_aresetn;
    logic                               trigger;
    snoop_pkg::snoop_req_t              snoop;
    snoop_pkg::ctrl_t                   ctrl;
    logic [snoop_pkg::CACHE_LINE_W-1:0] cache_line;
    logic                               crvalid;
    snoop_pkg::cr_payload_t             crresp;
    logic                               crready;
    logic                               cdvalid;
    logic [snoop_pkg::ACE_DATA_W-1:0]   cddata;
    logic                               cdlast;
    logic                               cdready;
    logic                               busy;
    logic                               done;
    logic                               oneshot_done;
    logic                               exp_start;
    snoop_pkg::cr_payload_t             exp_resp;
    int                                 exp_delay;
    int                                 exp_beats;
    logic                               exp_oneshot;
    int                                 errors;
    int                                 entries;
    logic [15:0]                        lfsr = 16'd18468;
    entry_t                             stim_table [N_ENTRIES];

    always #CLK_HALF ace_aclk = ~ace_aclk;

    passive_snoop_responder i_passive_snoop_responder
    (
        .ace_aclk (ace_aclk), .ace_aresetn (ace_aresetn), .i_trigger (trigger),
        .i_snoop (snoop), .i_ctrl (ctrl), .i_cache_line (cache_line),
        .o_crvalid (crvalid), .o_crresp (crresp), .i_crready (crready),
        .o_cdvalid (cdvalid), .o_cddata (cddata), .o_cdlast (cdlast), .i_cdready (cdready),
        .o_busy (busy), .o_done (done), .o_oneshot_done (oneshot_done)
    );

    snoop_checker i_snoop_checker
    (
        .ace_aclk (ace_aclk), .ace_aresetn (ace_aresetn),
        .i_crvalid (crvalid), .i_crresp (crresp), .i_crready (crready),
        .i_cdvalid (cdvalid), .i_cddata (cddata), .i_cdlast (cdlast), .i_cdready (cdready),
        .i_busy (busy), .i_done (done), .i_oneshot_done (oneshot_done),
        .i_exp_start (exp_start), .i_exp_resp (exp_resp), .i_exp_delay (exp_delay),
        .i_exp_beats (exp_beats), .i_exp_oneshot (exp_oneshot), .i_exp_line (cache_line),
        .o_errors (errors), .o_entries (entries)
    );

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // 0 for field 0, else 16 << (field - 1)
    function automatic int reply_delay_cycles(input logic [3:0] field);
        if (field == 4'd0)
            return 0;
        return int'(snoop_pkg::BASE_DELAY_CYCLES) << (field - 1);
    endfunction

    function automatic snoop_pkg::ctrl_t make_ctrl(input logic en, input logic [3:0] func,
        input logic [4:0] resp, input logic ac_f, input logic addr_f, input logic fen,
        input logic [3:0] delay);
        snoop_pkg::ctrl_t c;
        c.enable         = en;
        c.func           = func;
        c.crresp         = resp;
        c.ac_filter_en   = ac_f;
        c.addr_filter_en = addr_f;
        c.osh_en         = fen;
        c.con_en         = fen;
        c.pdt_en         = fen;
        c.delay          = delay;
        c.acsnoop_match  = 4'h7;
        c.base_addr      = 32'h0000_1000;
        c.addr_size      = 32'h0000_0100;
        return c;
    endfunction

    function automatic logic [snoop_pkg::CACHE_LINE_W-1:0] line_pattern(input logic [31:0] tag);
        logic [snoop_pkg::CACHE_LINE_W-1:0] l;
        for (int k = 0; k < snoop_pkg::CD_BEATS; k++)
            l[k*snoop_pkg::ACE_DATA_W +: snoop_pkg::ACE_DATA_W] =
                {tag ^ 32'(k), 32'h1111_1111 * 32'(k + 1), ~tag, 32'(k)};
        return l;
    endfunction

    function automatic entry_t make_entry(input snoop_pkg::ctrl_t c, input logic [43:0] addr,
        input logic [3:0] acsnoop, input logic [31:0] tag, input logic [1:0] cls,
        input logic retrig, input logic oneshot);
        entry_t e;
        e.ctrl          = c;
        e.snoop.addr    = addr;
        e.snoop.acsnoop = acsnoop;
        e.line          = line_pattern(tag);
        e.cls           = cls;
        e.retrig        = retrig;
        e.oneshot       = oneshot;
        return e;
    endfunction

    task automatic fill_table();
        stim_table[0]  = make_entry(make_ctrl(1, 4'h2, 5'h03, 1, 0, 1, 1), 44'h0AB_0000_1040,
                                    4'h1, 32'h0, CLS_DUMMY, 0, 0);
        stim_table[1]  = make_entry(make_ctrl(1, 4'h2, 5'h03, 0, 1, 1, 1), 44'h0AB_0000_2000,
                                    4'h7, 32'h0, CLS_DUMMY, 0, 0);
        // One-shot, then again, then rearmed through enable low
        stim_table[2]  = make_entry(make_ctrl(1, 4'h1, 5'h09, 1, 1, 1, 1), 44'h0AB_0000_1040,
                                    4'h7, 32'h0, CLS_DELAY, 1, 1);
        stim_table[3]  = make_entry(make_ctrl(1, 4'h1, 5'h09, 1, 1, 1, 1), 44'h0AB_0000_1040,
                                    4'h7, 32'h0, CLS_DUMMY, 0, 1);
        stim_table[4]  = make_entry(make_ctrl(0, 4'h2, 5'h11, 0, 0, 1, 2), 44'h000_0000_0000,
                                    4'h0, 32'h0, CLS_DELAY, 0, 0);
        stim_table[5]  = make_entry(make_ctrl(1, 4'h1, 5'h1F, 1, 1, 1, 1), 44'h0AB_0000_10FC,
                                    4'h7, 32'h0, CLS_DELAY, 0, 1);
        stim_table[6]  = make_entry(make_ctrl(1, 4'h2, 5'h05, 1, 1, 1, 0), 44'h0AB_0000_1000,
                                    4'h7, 32'h0, CLS_DELAY, 0, 1);
        // Data tampering
        stim_table[7]  = make_entry(make_ctrl(1, 4'h5, 5'h0B, 1, 1, 1, 0), 44'h0AB_0000_1080,
                                    4'h7, 32'hCAFE_0001, CLS_DATA, 0, 1);
        stim_table[8]  = make_entry(make_ctrl(1, 4'h5, 5'h0E, 0, 0, 1, 3), 44'h123_4567_89AB,
                                    4'h3, 32'h5A5A_A5A5, CLS_DATA, 0, 1);
        stim_table[9]  = make_entry(make_ctrl(1, 4'hF, 5'h0B, 0, 0, 1, 1), 44'h0AB_0000_1040,
                                    4'h7, 32'h0, CLS_DUMMY, 0, 1);
        stim_table[10] = make_entry(make_ctrl(1, 4'h2, 5'h0B, 0, 0, 0, 1), 44'h0AB_0000_1040,
                                    4'h7, 32'h0, CLS_DUMMY, 0, 1);
    endtask

    // Random back-pressure, one LFSR step per ready bit
    always @(posedge ace_aclk)
    begin
        #2;
        crready = lfsr[0];
        lfsr    = lfsr_next(lfsr);
        cdready = lfsr[0];
        lfsr    = lfsr_next(lfsr);
    end

    task automatic run_entry(input entry_t e);
        @(posedge ace_aclk);
        #2;
        ctrl        = e.ctrl;
        snoop       = e.snoop;
        cache_line  = e.line;
        exp_resp    = (e.cls == CLS_DUMMY) ? 5'h00 : e.ctrl.crresp;
        exp_delay   = (e.cls == CLS_DELAY) ? reply_delay_cycles(e.ctrl.delay) : 0;
        exp_beats   = (e.cls == CLS_DATA) ? snoop_pkg::CD_BEATS : 0;
        exp_oneshot = e.oneshot;
        trigger     = 1'b1;
        exp_start   = 1'b1;
        @(posedge ace_aclk);
        #2;
        trigger   = 1'b0;
        exp_start = 1'b0;
        // Second trigger while busy must be ignored
        if (e.retrig)
        begin
            trigger = 1'b1;
            @(posedge ace_aclk);
            #2;
            trigger = 1'b0;
        end
        do
            @(negedge ace_aclk);
        while (!done);
    endtask

    initial
    begin
        ace_aresetn = 1'b0;
        trigger     = 1'b0;
        snoop       = '0;
        ctrl        = '0;
        cache_line  = '0;
        crready     = 1'b0;
        cdready     = 1'b0;
        exp_start   = 1'b0;
        exp_resp    = '0;
        exp_delay   = 0;
        exp_beats   = 0;
        exp_oneshot = 1'b0;
        fill_table();
        repeat (2) @(posedge ace_aclk);
        #2;
        ace_aresetn = 1'b1;
        for (int i = 0; i < N_ENTRIES; i++)
            run_entry(stim_table[i]);
        repeat (4) @(posedge ace_aclk);
        $display("%0d of %0d entries completed, %0d errors", entries, N_ENTRIES, errors);
        if (errors == 0 && entries == N_ENTRIES)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // --------------------
    // Watchdog
    // --------------------
    initial
    begin
        int worst;
        int limit_ns;
        #1;
        worst = 0;
        for (int i = 0; i < N_ENTRIES; i++)
            if (reply_delay_cycles(stim_table[i].ctrl.delay) > worst)
                worst = reply_delay_cycles(stim_table[i].ctrl.delay);
        limit_ns = N_ENTRIES * (worst + MARGIN_CYCLES) * 2 * CLK_HALF;
        #(limit_ns);
        $display("Timeout: a reply did not finish within %0d ns", limit_ns);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- bench/snoop_checker.sv
`timescale 1ns/1ps

module snoop_checker
(
    input  logic                               ace_aclk,
    input  logic                               ace_aresetn,
    input  logic                               i_crvalid,
    input  snoop_pkg::cr_payload_t             i_crresp,
    input  logic                               i_crready,
    input  logic                               i_cdvalid,
    input  logic [snoop_pkg::ACE_DATA_W-1:0]   i_cddata,
    input  logic                               i_cdlast,
    input  logic                               i_cdready,
    input  logic                               i_busy,
    input  logic                               i_done,
    input  logic                               i_oneshot_done,
    // Expected reply for the running entry
    input  logic                               i_exp_start,
    input  snoop_pkg::cr_payload_t             i_exp_resp,
    input  int                                 i_exp_delay,
    input  int                                 i_exp_beats,
    input  logic                               i_exp_oneshot,
    input  logic [snoop_pkg::CACHE_LINE_W-1:0] i_exp_line,
    output int                                 o_errors,
    output int                                 o_entries
);

    int   errors  = 0;
    int   entries = 0;
    int   cycles  = 0;
    int   cr_count;
    int   cd_count;
    logic active  = 1'b0;

    assign o_errors  = errors;
    assign o_entries = entries;

    // Sampled on the falling edge, away from input changes
    always @(negedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            if (i_crvalid || i_cdvalid || i_busy || i_done || i_oneshot_done)
            begin
                $display("Outputs not low during reset at %0t", $time);
                errors++;
            end
        end
        else
        begin
            if (i_exp_start)
            begin
                active   = 1'b1;
                cycles   = 0;
                cr_count = 0;
                cd_count = 0;
            end
            else if (active)
            begin
                cycles++;
            end
            if ((i_crvalid || i_cdvalid || i_done) && !active)
            begin
                $display("Reply seen with no snoop in flight at %0t", $time);
                errors++;
            end
            // Busy covers the whole reply up to the done cycle
            if (active && cycles > 0 && !i_done && !i_busy)
            begin
                $display("mismatch at %0t: busy low while a reply is in flight", $time);
                errors++;
            end
            // --------------------
            // CR transfer
            // --------------------
            if (i_crvalid && active && cr_count == 0 && cycles < i_exp_delay)
            begin
                $display("mismatch at %0t: CR valid after %0d cycles, expected at least %0d",
                         $time, cycles, i_exp_delay);
                errors++;
            end
            if (i_crvalid && i_crready && active)
            begin
                if (i_crresp != i_exp_resp)
                begin
                    $display("mismatch at %0t: crresp %h, expected %h", $time, i_crresp,
                             i_exp_resp);
                    errors++;
                end
                cr_count++;
            end
            // --------------------
            // CD beats
            // --------------------
            if (i_cdvalid && i_cdready && active)
            begin
                if (cr_count == 0 || cd_count >= snoop_pkg::CD_BEATS)
                begin
                    $display("CD beat out of order at %0t", $time);
                    errors++;
                end
                else
                begin
                    if (i_cddata != i_exp_line[cd_count*snoop_pkg::ACE_DATA_W +:
                                               snoop_pkg::ACE_DATA_W])
                    begin
                        $display("mismatch at %0t: CD beat %0d data %h", $time, cd_count,
                                 i_cddata);
                        errors++;
                    end
                    if (i_cdlast != (cd_count == snoop_pkg::CD_BEATS - 1))
                    begin
                        $display("mismatch at %0t: cdlast %b on beat %0d", $time, i_cdlast,
                                 cd_count);
                        errors++;
                    end
                end
                cd_count++;
            end
            if (i_done && active)
            begin
                if (i_busy || cr_count != 1 || cd_count != i_exp_beats)
                begin
                    $display("mismatch at %0t: done with busy %b, %0d CR, %0d CD beats",
                             $time, i_busy, cr_count, cd_count);
                    errors++;
                end
                if (i_oneshot_done != i_exp_oneshot)
                begin
                    $display("mismatch at %0t: oneshot_done %b", $time, i_oneshot_done);
                    errors++;
                end
                active = 1'b0;
                entries++;
            end
        end
    end

endmodule

//--- bench/snoop_sva.sv
`timescale 1ns/1ps

module snoop_sva
#(
    parameter type PAYLOAD_T = logic
)
(
    input logic     ace_aclk,
    input logic     ace_aresetn,
    input logic     i_valid,
    input logic     i_ready,
    input PAYLOAD_T i_payload
);

    // Valid stays up until the transfer
    valid_held: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (i_valid && !i_ready) |=> i_valid)
        else $error("valid dropped before the transfer");

    // Payload frozen while stalled
    payload_stable: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (i_valid && !i_ready) |=> $stable(i_payload))
        else $error("payload changed while valid was stalled");

    valid_after_reset: assert property (@(posedge ace_aclk) !ace_aresetn |=> !i_valid)
        else $error("valid high after reset");

endmodule

bind channel_hold snoop_sva #(.PAYLOAD_T(PAYLOAD_T)) i_snoop_sva
(
    .ace_aclk    (ace_aclk),
    .ace_aresetn (ace_aresetn),
    .i_valid     (o_valid),
    .i_ready     (i_ready),
    .i_payload   (o_payload)
);

//--- hdl/passive_snoop_responder.sv
`timescale 1ns/1ps

module passive_snoop_responder
(
    input  logic                               ace_aclk,
    input  logic                               ace_aresetn,
    input  logic                               i_trigger,
    input  snoop_pkg::snoop_req_t              i_snoop,
    input  snoop_pkg::ctrl_t                   i_ctrl,
    input  logic [snoop_pkg::CACHE_LINE_W-1:0] i_cache_line,
    // CR channel
    output logic                               o_crvalid,
    output snoop_pkg::cr_payload_t             o_crresp,
    input  logic                               i_crready,
    // CD channel
    output logic                               o_cdvalid,
    output logic [snoop_pkg::ACE_DATA_W-1:0]   o_cddata,
    output logic                               o_cdlast,
    input  logic                               i_cdready,
    // Status
    output logic                               o_busy,
    output logic                               o_done,
    output logic                               o_oneshot_done
);

    logic                   capture;
    logic                   match;
    logic                   timer_start;
    logic                   expired;
    logic                   cr_load;
    logic                   cr_fire;
    logic                   cd_load;
    logic                   cd_fire;
    snoop_pkg::cr_payload_t cr_payload;
    snoop_pkg::cd_payload_t cd_payload;
    snoop_pkg::cd_payload_t cd_out;

    assign o_cddata = cd_out.data;
    assign o_cdlast = cd_out.last;

    // --------------------
    // Control path
    // --------------------
    snoop_filter i_snoop_filter
    (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_capture   (capture),
        .i_snoop     (i_snoop),
        .i_ctrl      (i_ctrl),
        .o_match     (match)
    );

    reply_delay_timer i_reply_delay_timer
    (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_start     (timer_start),
        .i_delay     (i_ctrl.delay),
        .o_expired   (expired)
    );

    reply_fsm i_reply_fsm
    (
        .ace_aclk       (ace_aclk),
        .ace_aresetn    (ace_aresetn),
        .i_trigger      (i_trigger),
        .i_ctrl         (i_ctrl),
        .i_match        (match),
        .i_expired      (expired),
        .o_timer_start  (timer_start),
        .i_cache_line   (i_cache_line),
        .o_capture      (capture),
        .o_cr_load      (cr_load),
        .o_cr_payload   (cr_payload),
        .i_cr_fire      (cr_fire),
        .o_cd_load      (cd_load),
        .o_cd_payload   (cd_payload),
        .i_cd_fire      (cd_fire),
        .o_busy         (o_busy),
        .o_done         (o_done),
        .o_oneshot_done (o_oneshot_done)
    );

    // --------------------
    // Output channels
    // --------------------
    channel_hold #(.PAYLOAD_T(snoop_pkg::cr_payload_t)) i_cr_hold
    (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_load      (cr_load),
        .i_payload   (cr_payload),
        .i_ready     (i_crready),
        .o_valid     (o_crvalid),
        .o_payload   (o_crresp),
        .o_fire      (cr_fire)
    );

    channel_hold #(.PAYLOAD_T(snoop_pkg::cd_payload_t)) i_cd_hold
    (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_load      (cd_load),
        .i_payload   (cd_payload),
        .i_ready     (i_cdready),
        .o_valid     (o_cdvalid),
        .o_payload   (cd_out),
        .o_fire      (cd_fire)
    );

endmodule

//--- hdl/reply_fsm.sv
`timescale 1ns/1ps

module reply_fsm
(
    input  logic                                  ace_aclk,
    input  logic                                  ace_aresetn,
    input  logic                                  i_trigger,
    input  snoop_pkg::ctrl_t                      i_ctrl,
    input  logic                                  i_match,
    input  logic                                  i_expired,
    output logic                                  o_timer_start,
    input  logic [snoop_pkg::CACHE_LINE_W-1:0]    i_cache_line,
    output logic                                  o_capture,
    output logic                                  o_cr_load,
    output snoop_pkg::cr_payload_t                o_cr_payload,
    input  logic                                  i_cr_fire,
    output logic                                  o_cd_load,
    output snoop_pkg::cd_payload_t                o_cd_payload,
    input  logic                                  i_cd_fire,
    output logic                                  o_busy,
    output logic                                  o_done,
    output logic                                  o_oneshot_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FILTER,
        S_FUNCTION,
        S_DELAY,
        S_RESPONSE,
        S_DATA,
        S_FINISH
    } state_t;

    state_t                        state;
    state_t                        state_nxt;
    logic                          cr_load_nxt;
    logic                          cd_load_nxt;
    logic [snoop_pkg::BEAT_W-1:0]  beat;
    logic [snoop_pkg::BEAT_W-1:0]  beat_nxt;
    logic                          oneshot_flag;
    logic                          reply_data;
    logic                          reply_osh;
    logic                          func_ok;
    logic                          func_delay;
    logic                          func_data;
    logic                          func_osh;

    // Finish is the done cycle, a new trigger is taken there too
    assign o_busy         = (state != S_IDLE) && (state != S_FINISH);
    assign o_done         = (state == S_FINISH);
    assign o_capture      = i_trigger && !o_busy;
    assign o_oneshot_done = oneshot_flag;
    assign o_timer_start  = (state == S_FUNCTION) && func_ok && func_delay;

    // --------------------
    // Function decode
    // --------------------
    always_comb
    begin
        func_ok    = 1'b0;
        func_delay = 1'b0;
        func_data  = 1'b0;
        func_osh   = 1'b0;
        case (i_ctrl.func)
            snoop_pkg::FUNC_OSH:
            begin
                func_ok    = i_ctrl.osh_en && !oneshot_flag;
                func_delay = 1'b1;
                func_osh   = 1'b1;
            end
            snoop_pkg::FUNC_CON:
            begin
                func_ok    = i_ctrl.con_en;
                func_delay = 1'b1;
            end
            // Tampered data goes out without delay
            snoop_pkg::FUNC_PDT:
            begin
                func_ok   = i_ctrl.pdt_en;
                func_data = 1'b1;
            end
            default:
            begin
                func_ok = 1'b0;
            end
        endcase
    end

    // --------------------
    // Next state
    // --------------------
    always_comb
    begin
        state_nxt   = state;
        cr_load_nxt = 1'b0;
        cd_load_nxt = 1'b0;
        beat_nxt    = beat;
        case (state)
            S_IDLE, S_FINISH:
                state_nxt = i_trigger ? S_FILTER : S_IDLE;
            S_FILTER:
            begin
                // Miss goes straight to a dummy reply
                state_nxt   = i_match ? S_FUNCTION : S_RESPONSE;
                cr_load_nxt = !i_match;
            end
            S_FUNCTION:
            begin
                state_nxt   = (func_ok && func_delay) ? S_DELAY : S_RESPONSE;
                cr_load_nxt = !(func_ok && func_delay);
            end
            S_DELAY:
            begin
                state_nxt   = i_expired ? S_RESPONSE : S_DELAY;
                cr_load_nxt = i_expired;
            end
            S_RESPONSE:
            begin
                if (i_cr_fire)
                begin
                    state_nxt   = reply_data ? S_DATA : S_FINISH;
                    cd_load_nxt = reply_data;
                    beat_nxt    = '0;
                end
            end
            S_DATA:
            begin
                if (i_cd_fire)
                begin
                    if (beat == snoop_pkg::LAST_BEAT)
                    begin
                        state_nxt = S_FINISH;
                    end
                    else
                    begin
                        beat_nxt    = beat + 1'b1;
                        cd_load_nxt = 1'b1;
                    end
                end
            end
            default:
                state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state        <= S_IDLE;
            beat         <= '0;
            o_cr_load    <= 1'b0;
            o_cd_load    <= 1'b0;
            oneshot_flag <= 1'b0;
            reply_data   <= 1'b0;
            reply_osh    <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            beat      <= beat_nxt;
            o_cr_load <= cr_load_nxt;
            o_cd_load <= cd_load_nxt;
            if (state == S_FILTER)
            begin
                reply_data <= 1'b0;
                reply_osh  <= 1'b0;
            end
            else if (state == S_FUNCTION)
            begin
                reply_data <= func_ok && func_data;
                reply_osh  <= func_ok && func_osh;
            end
            // One-shot rearms only once the block is switched off
            if ((state == S_IDLE) && !i_ctrl.enable)
                oneshot_flag <= 1'b0;
            else if ((state == S_RESPONSE) && i_cr_fire && reply_osh)
                oneshot_flag <= 1'b1;
        end
    end

    // Payloads are settled by the time their load pulse is seen
    always_ff @(posedge ace_aclk)
    begin
        if (state == S_FILTER)
            o_cr_payload <= '0;
        else if (state == S_FUNCTION)
            o_cr_payload <= func_ok ? i_ctrl.crresp : '0;
        if (cd_load_nxt)
        begin
            o_cd_payload.data <= i_cache_line[beat_nxt*snoop_pkg::ACE_DATA_W +: snoop_pkg::ACE_DATA_W];
            o_cd_payload.last <= (beat_nxt == snoop_pkg::LAST_BEAT);
        end
    end

endmodule

//--- hdl/channel_hold.sv
`timescale 1ns/1ps

module channel_hold
#(
    parameter type PAYLOAD_T = logic
)
(
    input  logic     ace_aclk,
    input  logic     ace_aresetn,
    input  logic     i_load,
    input  PAYLOAD_T i_payload,
    input  logic     i_ready,
    output logic     o_valid,
    output PAYLOAD_T o_payload,
    output logic     o_fire
);

    // Transfer happens when both sides agree
    assign o_fire = o_valid && i_ready;

    // --------------------
    // Valid flag
    // --------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_valid <= 1'b0;
        end
        else if (i_load)
        begin
            o_valid <= 1'b1;
        end
        else if (o_fire)
        begin
            o_valid <= 1'b0;
        end
    end

    // Payload frozen from load until the transfer
    always_ff @(posedge ace_aclk)
    begin
        if (i_load)
            o_payload <= i_payload;
    end

endmodule

//--- hdl/reply_delay_timer.sv
`timescale 1ns/1ps

module reply_delay_timer
(
    input  logic       ace_aclk,
    input  logic       ace_aresetn,
    input  logic       i_start,
    input  logic [3:0] i_delay,
    output logic       o_expired
);

    logic [snoop_pkg::DELAY_CNT_W-1:0] delay_cycles;
    logic [snoop_pkg::DELAY_CNT_W-1:0] count;
    logic                              active;

    // Delay field 0 means no wait, n means 16 << (n - 1) cycles
    always_comb
    begin
        if (i_delay == 4'd0)
            delay_cycles = '0;
        else
            delay_cycles = snoop_pkg::BASE_DELAY_CYCLES << (i_delay - 4'd1);
    end

    assign o_expired = active && (count == '0);

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            active <= 1'b0;
            count  <= '0;
        end
        else if (i_start)
        begin
            active <= 1'b1;
            count  <= delay_cycles;
        end
        else if (active)
        begin
            // Expiry is a single cycle
            if (count == '0)
                active <= 1'b0;
            else
                count <= count - 1'b1;
        end
    end

endmodule

//--- hdl/snoop_filter.sv
`timescale 1ns/1ps

module snoop_filter
(
    input  logic                  ace_aclk,
    input  logic                  ace_aresetn,
    input  logic                  i_capture,
    input  snoop_pkg::snoop_req_t i_snoop,
    input  snoop_pkg::ctrl_t      i_ctrl,
    output logic                  o_match
);

    logic [snoop_pkg::FILTER_ADDR_W-1:0] addr_low;
    logic [snoop_pkg::FILTER_ADDR_W:0]   addr_end;
    logic                                type_hit;
    logic                                addr_hit;
    logic                                pass;

    // --------------------
    // Filter terms
    // --------------------
    assign addr_low = i_snoop.addr[snoop_pkg::FILTER_ADDR_W-1:0];

    // Extra bit so a window at the top of the space does not wrap
    assign addr_end = {1'b0, i_ctrl.base_addr} + {1'b0, i_ctrl.addr_size};

    assign type_hit = (i_snoop.acsnoop == i_ctrl.acsnoop_match);
    assign addr_hit = (addr_low >= i_ctrl.base_addr) && ({1'b0, addr_low} < addr_end);

    // Disabled filter always passes
    assign pass = (!i_ctrl.ac_filter_en || type_hit) && (!i_ctrl.addr_filter_en || addr_hit);

    // Match is held until the next capture
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_match <= 1'b0;
        end
        else if (i_capture)
        begin
            o_match <= pass;
        end
    end

endmodule

//--- hdl/snoop_pkg.sv
package snoop_pkg;

    // --------------------
    // ACE widths
    // --------------------
    localparam int ACE_ADDR_W   = 44;
    localparam int ACE_DATA_W   = 128;
    localparam int CD_BEATS     = 4;
    localparam int CACHE_LINE_W = ACE_DATA_W * CD_BEATS;
    localparam int BEAT_W       = $clog2(CD_BEATS);

    // Index of the beat that carries cdlast
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(CD_BEATS - 1);

    // Only the low part of the snoop address is windowed
    localparam int FILTER_ADDR_W = 32;

    // --------------------
    // Reply delay
    // --------------------
    // Longest delay is 16 << 14 cycles
    localparam int DELAY_CNT_W = 20;
    localparam logic [DELAY_CNT_W-1:0] BASE_DELAY_CYCLES = 16;

    // --------------------
    // Function codes
    // --------------------
    // Any other code gets a dummy reply
    localparam logic [3:0] FUNC_OSH = 4'h1;
    localparam logic [3:0] FUNC_CON = 4'h2;
    localparam logic [3:0] FUNC_PDT = 4'h5;

    // Captured snoop from the AC channel
    typedef struct packed {
        logic [ACE_ADDR_W-1:0] addr;
        logic [3:0]            acsnoop;
    } snoop_req_t;

    // Control word
    typedef struct packed {
        logic                     enable;
        logic [3:0]               func;
        logic [4:0]               crresp;
        logic                     ac_filter_en;
        logic                     addr_filter_en;
        logic                     osh_en;
        logic                     con_en;
        logic                     pdt_en;
        logic [3:0]               delay;
        logic [3:0]               acsnoop_match;
        logic [FILTER_ADDR_W-1:0] base_addr;
        logic [FILTER_ADDR_W-1:0] addr_size;
    } ctrl_t;

    typedef logic [4:0] cr_payload_t;

    // One CD beat
    typedef struct packed {
        logic [ACE_DATA_W-1:0] data;
        logic                  last;
    } cd_payload_t;

endpackage
